// File: verilog/game_geometry_pkg.sv
package game_geometry_pkg;

	// pixel buffer
	localparam int screen_w = 160;
	localparam int screen_h = 120;
	localparam int x_w = 8;
	localparam int y_w = 7;

	// note lanes
	localparam int num_lanes = 3;
	localparam logic [x_w-1:0] lane_x [num_lanes] = '{8'd32, 8'd78, 8'd124};
	localparam logic [8:0] lane_colour [num_lanes] = '{
		9'b111_000_000, // red
		9'b000_111_000, // green
		9'b000_000_111  // blue
	};
	localparam int block_side = 4;
	localparam int block_pixels = 16;
	localparam int lane_y_start = 1;
	localparam int lane_step = 7;
	localparam int lane_wrap_y = 116; // lowest row a block may occupy
	localparam int hit_y_min = 90;
	localparam int hit_y_max = 108;

	// score area, bottom right corner
	localparam int score_x = 140;
	localparam int score_y = 110;
	localparam int digit2_x = 148;
	localparam int score_clear_w = 32;
	localparam int score_clear_h = 7;
	localparam int score_clear_pixels = 224;
	localparam int glyph_side = 8;
	localparam int glyph_pixels = 64;

	// msb is top-left, one byte per row
	localparam logic [63:0] digit_glyphs [10] = '{
		64'h3c666e7666663c00, 64'h1838181818187e00,
		64'h3c66060c30607e00, 64'h3c66061c06663c00,
		64'h0c1c3c6c7e0c0c00, 64'h7e607c0606663c00,
		64'h3c607c6666663c00, 64'h7e060c1830303000,
		64'h3c66663c66663c00, 64'h3c66663e060c3800
	};

	// timing
	localparam int ticks_per_step = 15;
	localparam int tick_divisors [4] = '{1, 2, 4, 8}; // 60 hz, 120, 240, 480

endpackage

// File: verilog/draw_types_pkg.sv
package draw_types_pkg;

	// 3 bits per channel, r in the msbs
	typedef logic [8:0] colour_t;

	localparam colour_t white = 9'h1ff;
	localparam colour_t black = 9'h000;

	typedef logic [1:0] speed_t; // 0 slowest
	typedef logic [6:0] score_t; // only 0..99 drawn sensibly

	typedef struct packed {
		logic valid;
		logic [game_geometry_pkg::x_w-1:0] x;
		logic [game_geometry_pkg::y_w-1:0] y;
		colour_t colour;
	} pixel_t;

	typedef struct packed {
		logic erase;
		logic step;
		logic paint;
	} lane_cmd_t;

	typedef struct packed {
		logic blank;
		logic digit_hi;
		logic digit_lo;
	} score_cmd_t;

	typedef enum logic [4:0] {
		st_idle,
		st_erase0, st_step0, st_paint0,
		st_erase1, st_step1, st_paint1,
		st_erase2, st_step2, st_paint2,
		st_blank,
		st_digit_hi,
		st_digit_lo
	} seq_state_t;

endpackage

// File: verilog/frame_tick.sv
`timescale 1ns/10ps

module frame_tick
	import game_geometry_pkg::*;
	import draw_types_pkg::*;
#(
	parameter int clk_hz = 50_000_000
) (
	input  logic   clk,
	input  logic   resetn,
	input  speed_t speed,
	output logic   step
);

	localparam int tick_clocks = clk_hz / 60; // clocks per 60 hz tick
	localparam int cnt_w = $clog2(tick_clocks);
	localparam int step_w = $clog2(ticks_per_step);

	logic [cnt_w-1:0]  reload;
	logic [cnt_w-1:0]  tick_cnt;
	logic [step_w-1:0] step_cnt;
	logic              tick;

	// constant table per speed, no divider in hardware
	always_comb begin
		case (speed)
			2'd0: reload = cnt_w'(tick_clocks / tick_divisors[0] - 1);
			2'd1: reload = cnt_w'(tick_clocks / tick_divisors[1] - 1);
			2'd2: reload = cnt_w'(tick_clocks / tick_divisors[2] - 1);
			default: reload = cnt_w'(tick_clocks / tick_divisors[3] - 1);
		endcase
	end

	assign tick = (tick_cnt == '0);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			tick_cnt <= reload;
			step_cnt <= '0;
			step <= 1'b0;
		end else begin
			tick_cnt <= tick ? reload : tick_cnt - 1'b1; // new speed picked up here
			step <= 1'b0;
			if (tick) begin
				if (step_cnt == step_w'(ticks_per_step - 1)) begin
					step_cnt <= '0;
					step <= 1'b1;
				end else begin
					step_cnt <= step_cnt + 1'b1;
				end
			end
		end
	end

endmodule

// File: verilog/draw_sequencer.sv
`timescale 1ns/10ps

module draw_sequencer
	import game_geometry_pkg::*;
	import draw_types_pkg::*;
(
	input  logic                             clk,
	input  logic                             resetn,
	input  logic                             step,
	input  logic [num_lanes-1:0]             lane_done,
	input  logic                             score_done,
	output lane_cmd_t [num_lanes-1:0]        lane_cmd,
	output score_cmd_t                       score_cmd
);

	seq_state_t state, state_next;

	// painters raise done in their last command cycle, so every
	// erase and paint state lasts exactly block_pixels cycles
	always_comb begin
		state_next = state;
		case (state)
			st_idle:     if (step) state_next = st_erase0; // mid-pass steps are dropped
			st_erase0:   if (lane_done[0]) state_next = st_step0;
			st_step0:    state_next = st_paint0;
			st_paint0:   if (lane_done[0]) state_next = st_erase1;
			st_erase1:   if (lane_done[1]) state_next = st_step1;
			st_step1:    state_next = st_paint1;
			st_paint1:   if (lane_done[1]) state_next = st_erase2;
			st_erase2:   if (lane_done[2]) state_next = st_step2;
			st_step2:    state_next = st_paint2;
			st_paint2:   if (lane_done[2]) state_next = st_blank;
			st_blank:    if (score_done) state_next = st_digit_hi;
			st_digit_hi: if (score_done) state_next = st_digit_lo;
			st_digit_lo: if (score_done) state_next = st_idle;
			default:     state_next = st_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!resetn)
			state <= st_idle;
		else
			state <= state_next;
	end

	// moore outputs
	always_comb begin
		lane_cmd = '0;
		score_cmd = '0;
		case (state)
			st_erase0:   lane_cmd[0].erase = 1'b1;
			st_step0:    lane_cmd[0].step = 1'b1;
			st_paint0:   lane_cmd[0].paint = 1'b1;
			st_erase1:   lane_cmd[1].erase = 1'b1;
			st_step1:    lane_cmd[1].step = 1'b1;
			st_paint1:   lane_cmd[1].paint = 1'b1;
			st_erase2:   lane_cmd[2].erase = 1'b1;
			st_step2:    lane_cmd[2].step = 1'b1;
			st_paint2:   lane_cmd[2].paint = 1'b1;
			st_blank:    score_cmd.blank = 1'b1;
			st_digit_hi: score_cmd.digit_hi = 1'b1;
			st_digit_lo: score_cmd.digit_lo = 1'b1;
			default:     ; // idle, nothing drawn
		endcase
	end

endmodule

// File: verilog/lane_painter.sv
`timescale 1ns/10ps

module lane_painter
	import game_geometry_pkg::*;
	import draw_types_pkg::*;
#(
	parameter int lane_index = 0
) (
	input  logic      clk,
	input  logic      resetn,
	input  lane_cmd_t cmd,
	output pixel_t    pixel,
	output logic      done,
	output logic      hit
);

	logic [3:0]     pix_cnt; // low bits column, high bits row
	logic [y_w-1:0] row;
	logic [y_w-1:0] row_next;
	logic           drawing;

	assign drawing = cmd.erase | cmd.paint;
	assign done = drawing && (pix_cnt == 4'(block_pixels - 1));

	// wrap as soon as the next row would pass the bottom limit
	always_comb begin
		if (({1'b0, row} + (y_w + 1)'(lane_step)) > (y_w + 1)'(lane_wrap_y))
			row_next = '0;
		else
			row_next = row + y_w'(lane_step);
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			pix_cnt <= '0;
			row <= y_w'(lane_y_start);
			hit <= 1'b0;
		end else begin
			if (drawing)
				pix_cnt <= pix_cnt + 1'b1; // back to 0 after the 16th pixel
			if (cmd.step) begin
				row <= row_next;
				hit <= (row_next >= y_w'(hit_y_min)) && (row_next <= y_w'(hit_y_max));
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			pixel.valid <= 1'b0;
		end else begin
			pixel.valid <= drawing;
			pixel.x <= lane_x[lane_index] + x_w'(pix_cnt[1:0]);
			pixel.y <= row + y_w'(pix_cnt[3:2]);
			pixel.colour <= cmd.erase ? white : colour_t'(lane_colour[lane_index]);
		end
	end

endmodule

// File: verilog/score_painter.sv
`timescale 1ns/10ps

module score_painter
	import game_geometry_pkg::*;
	import draw_types_pkg::*;
(
	input  logic       clk,
	input  logic       resetn,
	input  score_cmd_t cmd,
	input  score_t     score,
	output pixel_t     pixel,
	output logic       done
);

	logic [3:0]  tens;
	logic [3:0]  units;
	logic [63:0] glyph_bits;
	logic [7:0]  blank_cnt; // [4:0] column, [7:5] row
	logic [5:0]  glyph_cnt; // [2:0] column, [5:3] row
	logic        blank_last;
	logic        glyph_last;
	logic        glyph_on;

	// scores above 99 still give a valid digit
	assign tens = 4'((score / 10) % 10);
	assign units = 4'(score % 10);

	assign glyph_on = cmd.digit_hi | cmd.digit_lo;
	assign glyph_bits = cmd.digit_hi ? digit_glyphs[tens] : digit_glyphs[units];

	assign blank_last = (blank_cnt == 8'(score_clear_pixels - 1));
	assign glyph_last = (glyph_cnt == 6'(glyph_pixels - 1));
	assign done = (cmd.blank && blank_last) || (glyph_on && glyph_last);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			blank_cnt <= '0;
			glyph_cnt <= '0;
		end else begin
			if (cmd.blank)
				blank_cnt <= blank_last ? '0 : blank_cnt + 1'b1;
			if (glyph_on)
				glyph_cnt <= glyph_cnt + 1'b1; // shared by both digits
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			pixel.valid <= 1'b0;
		end else begin
			pixel.valid <= cmd.blank | glyph_on;
			if (cmd.blank) begin
				pixel.x <= x_w'(score_x) + x_w'(blank_cnt[4:0]);
				pixel.y <= y_w'(score_y) + y_w'(blank_cnt[7:5]);
				pixel.colour <= white;
			end else begin
				pixel.x <= (cmd.digit_hi ? x_w'(score_x) : x_w'(digit2_x))
					+ x_w'(glyph_cnt[2:0]);
				pixel.y <= y_w'(score_y) + y_w'(glyph_cnt[5:3]);
				// 63 - count, msb first
				pixel.colour <= glyph_bits[~glyph_cnt] ? black : white;
			end
		end
	end

endmodule

// File: verilog/rhythm_display_top.sv
`timescale 1ns/10ps

module rhythm_display_top
	import game_geometry_pkg::*;
	import draw_types_pkg::*;
#(
	parameter int clk_hz = 50_000_000
) (
	input  logic                 clk,
	input  logic                 resetn,
	input  speed_t               speed,
	input  score_t               score,
	output pixel_t               pixel,
	output logic [num_lanes-1:0] hit
);

	logic                      step;
	logic [num_lanes-1:0]      lane_done;
	logic                      score_done;
	lane_cmd_t [num_lanes-1:0] lane_cmd;
	score_cmd_t                score_cmd;
	pixel_t [num_lanes-1:0]    lane_pixel;
	pixel_t                    score_pixel;

	frame_tick #(.clk_hz(clk_hz)) tick0 (
		.clk(clk),
		.resetn(resetn),
		.speed(speed),
		.step(step)
	);

	draw_sequencer seq0 (
		.clk(clk),
		.resetn(resetn),
		.step(step),
		.lane_done(lane_done),
		.score_done(score_done),
		.lane_cmd(lane_cmd),
		.score_cmd(score_cmd)
	);

	for (genvar i = 0; i < num_lanes; i++) begin : g_lane
		lane_painter #(.lane_index(i)) lane (
			.clk(clk),
			.resetn(resetn),
			.cmd(lane_cmd[i]),
			.pixel(lane_pixel[i]),
			.done(lane_done[i]),
			.hit(hit[i])
		);
	end

	score_painter score0 (
		.clk(clk),
		.resetn(resetn),
		.cmd(score_cmd),
		.score(score),
		.pixel(score_pixel),
		.done(score_done)
	);

	// one painter at a time, idle payloads may be stale
	always_comb begin
		pixel = score_pixel;
		for (int i = 0; i < num_lanes; i++) begin
			if (lane_pixel[i].valid)
				pixel = lane_pixel[i];
		end
	end

endmodule

// File: verification/rhythm_display_properties.sv
`timescale 1ns/10ps

module rhythm_display_properties
	import game_geometry_pkg::*;
	import draw_types_pkg::*;
(
	input logic                      clk,
	input logic                      resetn,
	input pixel_t                    pixel,
	input logic [num_lanes-1:0]      hit,
	input lane_cmd_t [num_lanes-1:0] lane_cmd
);

	logic step_any;
	logic in_score_strip;

	always_comb begin
		step_any = 1'b0;
		for (int i = 0; i < num_lanes; i++)
			step_any = step_any | lane_cmd[i].step;
	end

	// the score blank runs past the right edge of the buffer
	assign in_score_strip = (pixel.y >= score_y) && (pixel.x < score_x + score_clear_w);

	a_reset_quiet: assert property (@(posedge clk) !resetn |=> !pixel.valid)
		else $error("pixel valid while in reset");

	a_on_screen: assert property (@(posedge clk) disable iff (!resetn)
		pixel.valid |-> (pixel.y < screen_h) && ((pixel.x < screen_w) || in_score_strip))
		else $error("pixel outside the buffer x=%0d y=%0d", pixel.x, pixel.y);

	a_hit_after_step: assert property (@(posedge clk) disable iff (!resetn)
		$changed(hit) |-> $past(step_any))
		else $error("hit changed without a lane step");

endmodule

// File: verification/tb_rhythm_display.sv
`timescale 1ns/10ps

module tb_rhythm_display
	import game_geometry_pkg::*;
	import draw_types_pkg::*;
();

	localparam int clk_hz = 4800;
	localparam int tick_clocks = clk_hz / 60; // 80 clocks at speed 0
	localparam int step_clocks = ticks_per_step * tick_clocks;
	localparam int pass_cycles = num_lanes * (2 * block_pixels + 1)
		+ score_clear_pixels + 2 * glyph_pixels;
	localparam int wait_limit = 2 * step_clocks;
	localparam int watchdog_cycles = 40 * step_clocks;

	logic                 clk;
	logic                 resetn;
	speed_t               speed;
	score_t               score;
	pixel_t               pixel;
	logic [num_lanes-1:0] hit;

	int     cycle = 0;
	int     errors = 0;
	int     checks = 0;
	int     model_row [num_lanes];
	pixel_t got_q [$];
	pixel_t exp_q [$];

	rhythm_display_top #(.clk_hz(clk_hz)) dut0 (
		.clk(clk),
		.resetn(resetn),
		.speed(speed),
		.score(score),
		.pixel(pixel),
		.hit(hit)
	);

	bind rhythm_display_top rhythm_display_properties props0 (
		.clk(clk),
		.resetn(resetn),
		.pixel(pixel),
		.hit(hit),
		.lane_cmd(lane_cmd)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) cycle <= cycle + 1;

	task automatic check_pixel(input pixel_t got, input pixel_t exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t: %s got (%0d,%0d) %h v%b, expected (%0d,%0d) %h",
				$time, what, got.x, got.y, got.colour, got.valid, exp.x, exp.y, exp.colour);
		end
	endtask

	task automatic check_hit(input logic [num_lanes-1:0] got, input logic [num_lanes-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t: hit is %b, expected %b", $time, got, exp);
		end
	endtask

	task automatic check_count(input int got, input int exp, input string what);
		checks++;
		if (got != exp) begin
			errors++;
			$display("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	function automatic pixel_t make_pixel(input int x, input int y, input colour_t c);
		pixel_t p;
		p.valid = 1'b1;
		p.x = x_w'(x);
		p.y = y_w'(y);
		p.colour = c;
		return p;
	endfunction

	function automatic int next_row(input int row);
		if (row + lane_step > lane_wrap_y) // block would run off the bottom
			return 0;
		return row + lane_step;
	endfunction

	// reference pass, advances the model rows
	task automatic build_expected(output logic [num_lanes-1:0] exp_hit);
		int new_row;
		int d;
		exp_q.delete();
		for (int l = 0; l < num_lanes; l++) begin
			new_row = next_row(model_row[l]);
			for (int i = 0; i < block_pixels; i++)
				exp_q.push_back(make_pixel(lane_x[l] + i % block_side,
					model_row[l] + i / block_side, white));
			for (int i = 0; i < block_pixels; i++)
				exp_q.push_back(make_pixel(lane_x[l] + i % block_side,
					new_row + i / block_side, lane_colour[l]));
			model_row[l] = new_row;
			exp_hit[l] = (new_row >= hit_y_min) && (new_row <= hit_y_max);
		end
		for (int i = 0; i < score_clear_pixels; i++)
			exp_q.push_back(make_pixel(score_x + i % score_clear_w,
				score_y + i / score_clear_w, white));
		for (int k = 0; k < 2; k++) begin
			d = (k == 0) ? (int'(score) / 10) % 10 : int'(score) % 10;
			for (int i = 0; i < glyph_pixels; i++)
				exp_q.push_back(make_pixel((k == 0 ? score_x : digit2_x) + i % glyph_side,
					score_y + i / glyph_side, digit_glyphs[d][63 - i] ? black : white));
		end
	endtask

	// gathers valid pixels until the stream has been quiet for a while
	task automatic collect_pass(output int start_cycle);
		int idle_run;
		int waited;
		got_q.delete();
		waited = 0;
		start_cycle = -1;
		@(negedge clk);
		while (!pixel.valid && waited < wait_limit) begin
			@(negedge clk);
			waited++;
		end
		if (!pixel.valid) begin
			errors++;
			$display("no pass started within %0d clocks", wait_limit);
			return;
		end
		start_cycle = cycle;
		idle_run = 0;
		while (idle_run < 8) begin
			if (pixel.valid) begin
				got_q.push_back(pixel);
				idle_run = 0;
			end else begin
				idle_run++;
			end
			@(negedge clk);
		end
	endtask

	task automatic run_pass(output int start_cycle);
		logic [num_lanes-1:0] exp_hit;
		int n;
		build_expected(exp_hit);
		collect_pass(start_cycle);
		check_count(got_q.size(), exp_q.size(), "pixels in pass");
		n = (got_q.size() < exp_q.size()) ? got_q.size() : exp_q.size();
		for (int i = 0; i < n; i++)
			check_pixel(got_q[i], exp_q[i], $sformatf("pixel %0d", i));
		check_hit(hit, exp_hit);
	endtask

	// the first step is 15 ticks after reset, its pixels come later still
	task automatic test_reset_quiet();
		int n;
		n = 0;
		repeat (step_clocks) begin
			@(negedge clk);
			if (pixel.valid)
				n++;
		end
		check_count(n, 0, "valid pixels before first step");
		check_hit(hit, '0);
	endtask

	task automatic test_passes(input int passes);
		int t;
		repeat (passes) run_pass(t);
	endtask

	task automatic test_score_digits();
		int t;
		@(posedge clk);
		#1 score = 7'd47;
		run_pass(t);
		@(posedge clk);
		#1 score = 7'd5;
		run_pass(t);
	endtask

	task automatic test_pass_interval(input speed_t s);
		int t0;
		int t1;
		int t2;
		int period;
		int expected;
		@(posedge clk);
		#1 speed = s;
		run_pass(t0); // speed settles at the next reload
		run_pass(t1);
		run_pass(t2);
		period = ticks_per_step * (tick_clocks / tick_divisors[s]);
		expected = period;
		while (expected <= pass_cycles) // steps during a pass are dropped
			expected += period;
		check_count(t2 - t1, expected, $sformatf("clocks between passes at speed %0d", s));
	endtask

	initial begin
		repeat (watchdog_cycles) @(posedge clk);
		$display("timeout, the run did not finish within %0d clocks", watchdog_cycles);
		$display("Testbench failed");
		$finish;
	end

	initial begin
		resetn = 1'b0;
		speed = '0;
		score = 7'd0;
		for (int l = 0; l < num_lanes; l++)
			model_row[l] = lane_y_start;
		repeat (10) @(posedge clk);
		#1 resetn = 1'b1;
		test_reset_quiet();
		test_passes(1);
		test_passes(18);
		test_score_digits();
		test_pass_interval(2'd0);
		test_pass_interval(2'd3);
		$display("summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

// File: sim.f
verilog/game_geometry_pkg.sv
verilog/draw_types_pkg.sv
verilog/frame_tick.sv
verilog/draw_sequencer.sv
verilog/lane_painter.sv
verilog/score_painter.sv
verilog/rhythm_display_top.sv
verification/rhythm_display_properties.sv
verification/tb_rhythm_display.sv

// File: Makefile
VERILATOR := verilator
TOP       := tb_rhythm_display
FILELIST  := sim.f
VFLAGS    := --binary --timing --assert -Wno-fatal --top-module $(TOP)
BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "Testbench failed" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	elif ! grep -q "Testbench passed" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
